//--- all.f
+incdir+include
src/isaPkg.sv
src/corePkg.sv
src/fetchUnit.sv
src/decodeUnit.sv
src/regFile.sv
src/executeUnit.sv
src/dataMemory.sv
src/mipsCore.sv
dv/coreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the core and testbench with Verilator, run, then judge by the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module coreTb -f all.f \
	&& ./obj_dir/VcoreTb | tee sim.log \
	|| echo "build or simulation did not complete"

grep -qx "PASS: all tests" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- include/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

logic [31:0] rngState = 32'd74458;
wordT mImem [imemDepth]; // program image, loaded into the DUT as is
wordT mRegs [32];
wordT mDmem [dmemDepth];
wordT mPc;

// xorshift32 step
function automatic logic [31:0] nextRand();
	rngState = rngState ^ (rngState << 13);
	rngState = rngState ^ (rngState >> 17);
	rngState = rngState ^ (rngState << 5);
	return rngState;
endfunction

function automatic int randBelow(int n);
	return int'(nextRand() % n);
endfunction

// architectural reset, program image is kept
task automatic modelReset();
	for (int i = 0; i < 32; i++)
		mRegs[i] = '0;
	for (int i = 0; i < dmemDepth; i++)
		mDmem[i] = '0;
	mPc = '0;
endtask

// execute one instruction at ISA level and return the expected trace
task automatic modelStep(output retireT exp);
	instrT w;
	wordT rsVal;
	wordT rtVal;
	wordT sImm;
	wordT zImm;
	wordT sum;
	wordT res;
	wordT nextPc;
	regIdxT dest;
	logic wr;
	logic [dmemAddrBits-1:0] addr;
	w = mImem[mPc[imemAddrBits-1:0]];
	rsVal = mRegs[w.r.rs];
	rtVal = mRegs[w.r.rt];
	sImm = {{16{w.i.imm[15]}}, w.i.imm};
	zImm = {16'h0000, w.i.imm};
	sum = rsVal + sImm; // effective address for lw and sw
	addr = sum[dmemAddrBits-1:0];
	nextPc = mPc + 32'd1;
	dest = w.i.rt;
	res = '0;
	wr = w.r.opcode inside {opRType, opAddi, opSlti, opAndi, opOri, opXori, opLui, opLw, opJal};
	exp = '0;
	exp.valid = 1'b1;
	exp.pc = mPc;
	case (w.r.opcode)
		opRType:
		begin
			dest = w.r.rd;
			case (w.r.funct)
				fnAdd: res = rsVal + rtVal;
				fnSub: res = rsVal - rtVal;
				fnAnd: res = rsVal & rtVal;
				fnOr:  res = rsVal | rtVal;
				fnXor: res = rsVal ^ rtVal;
				fnNor: res = ~(rsVal | rtVal);
				fnSlt: res = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
				fnSll: res = rtVal << w.r.shamt;
				fnSrl: res = rtVal >> w.r.shamt;
				fnSra: res = $signed(rtVal) >>> w.r.shamt;
				fnJr:
				begin
					wr = 1'b0;
					nextPc = rsVal;
				end
				default: wr = 1'b0; // unknown funct retires as a no-op
			endcase
		end
		opAddi: res = sum;
		opSlti: res = ($signed(rsVal) < $signed(sImm)) ? 32'd1 : 32'd0;
		opAndi: res = rsVal & zImm;
		opOri:  res = rsVal | zImm;
		opXori: res = rsVal ^ zImm;
		opLui:  res = {w.i.imm, 16'h0000};
		opLw:   res = mDmem[addr];
		opSw:
		begin
			exp.memWrite = 1'b1;
			exp.memAddr = addr;
			exp.memData = rtVal;
			mDmem[addr] = rtVal;
		end
		opBeq:
		begin
			if (rsVal == rtVal)
				nextPc = mPc + 32'd1 + sImm;
		end
		opBne:
		begin
			if (rsVal != rtVal)
				nextPc = mPc + 32'd1 + sImm;
		end
		opJ: nextPc = {6'b000000, w.j.target};
		opJal:
		begin
			dest = raReg;
			res = mPc + 32'd1;
			nextPc = {6'b000000, w.j.target};
		end
		default: wr = 1'b0;
	endcase
	if (wr && dest != '0)
	begin
		mRegs[dest] = res;
		exp.regWrite = 1'b1;
		exp.rd = dest;
		exp.regData = res;
	end
	mPc = nextPc;
endtask

`endif

//--- dv/coreTb.sv
module coreTb
	import isaPkg::*, corePkg::*;
();

	logic Clock;
	logic rst;
	logic run;
	progWriteT progWrite;
	retireT retire;

	int errCount = 0;
	int checkCount = 0;
	int testsRun = 0;
	int testsPassed = 0;
	logic stalled = 1'b0;

	`include "refModel.svh"

	mipsCore dut_i (
		.Clock(Clock),
		.rst(rst),
		.run(run),
		.progWrite(progWrite),
		.retire(retire)
	);

	initial
	begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	task automatic checkWord(wordT got, wordT exp, string what);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkRetire(retireT got, retireT exp, string what);
		checkCount++;
		if (got.valid !== exp.valid || got.regWrite !== exp.regWrite ||
			got.memWrite !== exp.memWrite)
		begin
			errCount++;
			$display("Mismatch at %0t: %s valid/regWrite/memWrite got %b%b%b expected %b%b%b",
				$time, what, got.valid, got.regWrite, got.memWrite,
				exp.valid, exp.regWrite, exp.memWrite);
		end
		if (exp.valid)
			checkWord(got.pc, exp.pc, {what, " pc"});
		if (exp.regWrite)
		begin
			checkWord(wordT'(got.rd), wordT'(exp.rd), {what, " rd"});
			checkWord(got.regData, exp.regData, {what, " regData"});
		end
		if (exp.memWrite)
		begin
			checkWord(wordT'(got.memAddr), wordT'(exp.memAddr), {what, " memAddr"});
			checkWord(got.memData, exp.memData, {what, " memData"});
		end
	endtask

	function automatic regIdxT smallReg();
		return regIdxT'(randBelow(8)); // r0 to r7 with r0 writes included
	endfunction

	// one kept or unknown instruction of category cat at address addr
	function automatic instrT genInstr(int cat, int addr, int len);
		instrT w;
		int pick;
		logic [31:0] off;
		functT aluFuncts [10];
		opcodeT immOps [6];
		logic [5:0] badOps [10];
		logic [5:0] badFuncts [4];
		aluFuncts = '{fnAdd, fnSub, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSll, fnSrl, fnSra};
		immOps = '{opAddi, opSlti, opAndi, opOri, opXori, opLui};
		badOps = '{6'd1, 6'd6, 6'd7, 6'd9, 6'd11, 6'd32, 6'd33, 6'd40, 6'd41, 6'd63};
		badFuncts = '{6'd1, 6'd4, 6'd33, 6'd35};
		w = nextRand(); // random fields with shamt and imm kept as drawn
		case (cat)
			0:
			begin
				w.r.opcode = opRType;
				w.r.rs = smallReg();
				w.r.rt = smallReg();
				w.r.rd = smallReg();
				w.r.funct = aluFuncts[randBelow(10)];
			end
			1:
			begin
				w.i.opcode = immOps[randBelow(6)];
				w.i.rs = smallReg();
				w.i.rt = smallReg();
			end
			2:
			begin
				w.i.opcode = (randBelow(2) == 0) ? opSw : opLw;
				w.i.rs = '0; // base r0 keeps addresses in 0..7
				w.i.rt = smallReg();
				w.i.imm = 16'(randBelow(8));
			end
			3:
			begin
				pick = randBelow(5);
				off = 32'(randBelow(len) - addr - 1); // branch lands inside the program
				if (pick < 2)
				begin
					w.i.opcode = (pick == 0) ? opBeq : opBne;
					w.i.rs = smallReg();
					w.i.rt = smallReg();
					w.i.imm = off[15:0];
				end
				else if (pick < 4)
				begin
					w.j.opcode = (pick == 2) ? opJ : opJal;
					w.j.target = 26'(randBelow(len));
				end
				else
				begin
					w = '0;
					w.r.opcode = opRType;
					w.r.rs = raReg; // only jal writes r31
					w.r.funct = fnJr;
				end
			end
			default:
			begin
				pick = randBelow(12);
				if (pick < 10)
					w.r.opcode = opcodeT'(badOps[pick]);
				else
				begin
					w.r.opcode = opRType;
					w.r.funct = functT'(badFuncts[pick - 10]);
				end
			end
		endcase
		return w;
	endfunction

	task automatic genProgram(logic [4:0] mask, int len);
		int cats [5];
		int nCats;
		instrT fill;
		nCats = 0;
		for (int c = 0; c < 5; c++)
		begin
			if (mask[c])
			begin
				cats[nCats] = c;
				nCats++;
			end
		end
		for (int a = 0; a < imemDepth; a++)
		begin
			if (a < len)
				mImem[a] = genInstr(cats[randBelow(nCats)], a, len);
			else
			begin
				fill = '0;
				fill.i.opcode = opBeq; // taken beq on r0 back to address 0
				fill.i.imm = 16'(-(a + 1));
				mImem[a] = fill;
			end
		end
	endtask

	task automatic loadProgram();
		for (int a = 0; a < imemDepth; a++)
		begin
			@(posedge Clock);
			#1;
			progWrite.strobe = 1'b1;
			progWrite.addr = 8'(a);
			progWrite.data = mImem[a];
		end
		@(posedge Clock);
		#1;
		progWrite = '0;
	endtask

	task automatic resetCore();
		@(posedge Clock);
		#1;
		rst = 1'b1;
		repeat (2) @(posedge Clock);
		#1;
		rst = 1'b0;
		modelReset();
	endtask

	task automatic runProgram(int steps);
		retireT exp;
		int waited;
		@(posedge Clock);
		#1;
		run = 1'b1;
		for (int k = 0; k < steps && !stalled; k++)
		begin
			waited = 0;
			@(negedge Clock); // retire is settled mid-cycle
			while (!retire.valid && waited < 10)
			begin
				@(negedge Clock);
				waited++;
			end
			if (!retire.valid)
			begin
				stalled = 1'b1;
				errCount++;
				$display("retirement stalled: nothing retired for 10 cycles with run high");
			end
			else
			begin
				modelStep(exp);
				checkRetire(retire, exp, $sformatf("retire %0d", k));
			end
		end
		@(posedge Clock); // last instruction commits here
		#1;
		run = 1'b0;
	endtask

	task automatic runTest(int num, string name, logic [4:0] mask, int len, int steps);
		int errsBefore;
		errsBefore = errCount;
		if (!stalled)
		begin
			genProgram(mask, len);
			loadProgram();
			resetCore();
			@(negedge Clock);
			checkRetire(retire, '0, "idle after reset");
			runProgram(steps);
			testsRun++;
			if (errCount == errsBefore)
				testsPassed++;
			$display("test %0d %s: %s", num, name, (errCount == errsBefore) ? "ok" : "errors");
		end
	endtask

	initial
	begin
		rst = 1'b1;
		run = 1'b0;
		progWrite = '0;
		// mask bits from bit 0 are aluR, aluImm, memory, flow and unknown
		runTest(1, "reset state", 5'b00001, 8, 8);
		runTest(2, "arithmetic logic shift", 5'b00011, 60, 60);
		runTest(3, "load store", 5'b00110, 60, 60);
		runTest(4, "branches jumps", 5'b01011, 40, 80);
		runTest(5, "unknown opcodes", 5'b10010, 40, 40);
		runTest(6, "long random run", 5'b01111, 200, 200);
		$display("%0d of %0d tests ok, %0d checks, %0d errors",
			testsPassed, testsRun, checkCount, errCount);
		if (errCount == 0 && !stalled)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- src/mipsCore.sv
module mipsCore
	import isaPkg::*, corePkg::*;
(
	input logic Clock,
	input logic rst,
	input logic run,
	input progWriteT progWrite,
	output retireT retire
);

	instrT instr;
	ctrlT ctrl;
	wordT imm;
	wordT pc;
	wordT pcPlusOne;
	wordT rsData;
	wordT rtData;
	wordT aluResult;
	wordT loadData;
	wordT writeBack;
	regIdxT writeReg;
	logic equal;
	logic regWriteEn;
	logic memWriteEn;

	fetchUnit fetch_i (
		.Clock(Clock),
		.rst(rst),
		.run(run),
		.progWrite(progWrite),
		.ctrl(ctrl),
		.equal(equal),
		.imm(imm),
		.rsData(rsData),
		.instr(instr),
		.pc(pc),
		.pcPlusOne(pcPlusOne)
	);

	decodeUnit decode_i (
		.instr(instr),
		.ctrl(ctrl),
		.imm(imm)
	);

	// destination: ra for jal, rd for R-type, rt otherwise
	always_comb
	begin
		if (ctrl.link)
			writeReg = raReg;
		else if (instr.r.opcode == opRType)
			writeReg = instr.r.rd;
		else
			writeReg = instr.i.rt;
	end

	assign writeBack = ctrl.link ? pcPlusOne : (ctrl.memToReg ? loadData : aluResult);
	assign regWriteEn = run && ctrl.regWrite; // nothing commits while stopped
	assign memWriteEn = run && ctrl.memWrite;

	regFile regs_i (
		.Clock(Clock),
		.rst(rst),
		.writeEn(regWriteEn),
		.rsIdx(instr.r.rs),
		.rtIdx(instr.r.rt),
		.rdIdx(writeReg),
		.writeData(writeBack),
		.rsData(rsData),
		.rtData(rtData)
	);

	executeUnit execute_i (
		.ctrl(ctrl),
		.instr(instr),
		.rsData(rsData),
		.rtData(rtData),
		.imm(imm),
		.aluResult(aluResult),
		.equal(equal)
	);

	dataMemory dmem_i (
		.Clock(Clock),
		.rst(rst),
		.writeEn(memWriteEn),
		.addr(aluResult[dmemAddrBits-1:0]),
		.writeData(rtData),
		.readData(loadData)
	);

	// trace of the instruction committing at this edge
	always_comb
	begin
		retire.valid = run;
		retire.pc = pc;
		retire.regWrite = regWriteEn && (writeReg != '0); // r0 writes are not architectural
		retire.rd = writeReg;
		retire.regData = writeBack;
		retire.memWrite = memWriteEn;
		retire.memAddr = aluResult[dmemAddrBits-1:0];
		retire.memData = rtData;
	end

endmodule

//--- src/dataMemory.sv
module dataMemory
	import corePkg::*;
(
	input logic Clock,
	input logic rst,
	input logic writeEn,
	input logic [dmemAddrBits-1:0] addr,
	input wordT writeData,
	output wordT readData
);

	wordT mem [dmemDepth];

	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			for (int i = 0; i < dmemDepth; i++)
				mem[i] <= '0; // data words start at zero
		end
		else if (writeEn)
			mem[addr] <= writeData;
	end

	assign readData = mem[addr]; // combinational read for lw

endmodule

//--- src/executeUnit.sv
module executeUnit
	import isaPkg::*, corePkg::*;
(
	input ctrlT ctrl,
	input instrT instr,
	input wordT rsData,
	input wordT rtData,
	input wordT imm,
	output wordT aluResult,
	output logic equal
);

	wordT opB;
	logic [4:0] shamt;

	assign opB = ctrl.aluSrcImm ? imm : rtData;
	assign shamt = instr.r.shamt;

	always_comb
	begin
		case (ctrl.aluOp)
			aluAnd: aluResult = rsData & opB;
			aluOr:  aluResult = rsData | opB;
			aluAdd: aluResult = rsData + opB;
			aluSub: aluResult = rsData - opB;
			aluXor: aluResult = rsData ^ opB;
			aluNor: aluResult = ~(rsData | opB);
			aluSlt: aluResult = ($signed(rsData) < $signed(opB)) ? 32'd1 : 32'd0;
			aluSll: aluResult = opB << shamt;
			aluSrl: aluResult = opB >> shamt;
			aluSra: aluResult = $signed(opB) >>> shamt; // keeps sign
			aluLui: aluResult = imm << 16;
			default: aluResult = '0;
		endcase
	end

	// branch compare on the two register reads
	assign equal = (rsData == rtData);

endmodule

//--- src/regFile.sv
module regFile
	import isaPkg::*, corePkg::*;
(
	input logic Clock,
	input logic rst,
	input logic writeEn,
	input regIdxT rsIdx,
	input regIdxT rtIdx,
	input regIdxT rdIdx,
	input wordT writeData,
	output wordT rsData,
	output wordT rtData
);

	wordT regs [32];

	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (writeEn && rdIdx != '0)
			regs[rdIdx] <= writeData; // r0 writes dropped
	end

	// combinational reads straight from storage
	assign rsData = regs[rsIdx];
	assign rtData = regs[rtIdx];

	// r0 must read zero on both ports whatever the core tried to write to it
	zeroRegRs: assert property (@(posedge Clock) disable iff (rst)
		rsIdx == '0 |-> rsData == '0)
		else $error("register 0 reads nonzero on the rs port");

	zeroRegRt: assert property (@(posedge Clock) disable iff (rst)
		rtIdx == '0 |-> rtData == '0)
		else $error("register 0 reads nonzero on the rt port");

endmodule

//--- src/decodeUnit.sv
module decodeUnit
	import isaPkg::*, corePkg::*;
(
	input instrT instr,
	output ctrlT ctrl,
	output wordT imm
);

	logic knownInstr;

	always_comb
	begin
		ctrl = '0;
		ctrl.aluOp = aluAdd; // address and addi default
		case (instr.r.opcode)
			opRType:
			begin
				ctrl.regWrite = 1'b1;
				case (instr.r.funct)
					fnAdd: ctrl.aluOp = aluAdd;
					fnSub: ctrl.aluOp = aluSub;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOr:  ctrl.aluOp = aluOr;
					fnXor: ctrl.aluOp = aluXor;
					fnNor: ctrl.aluOp = aluNor;
					fnSlt: ctrl.aluOp = aluSlt;
					fnSll: ctrl.aluOp = aluSll;
					fnSrl: ctrl.aluOp = aluSrl;
					fnSra: ctrl.aluOp = aluSra;
					fnJr:
					begin
						ctrl.regWrite = 1'b0;
						ctrl.jumpReg = 1'b1;
					end
					default: ctrl.regWrite = 1'b0; // unknown funct is a no-op
				endcase
			end
			opAddi:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			opSlti:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = aluSlt;
			end
			opAndi, opOri, opXori:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.zeroExtImm = 1'b1; // logical immediates
				if (instr.r.opcode == opAndi)
					ctrl.aluOp = aluAnd;
				else if (instr.r.opcode == opOri)
					ctrl.aluOp = aluOr;
				else
					ctrl.aluOp = aluXor;
			end
			opLui:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = aluLui;
			end
			opLw:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			opSw:
			begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			opBeq: ctrl.branchEq = 1'b1;
			opBne: ctrl.branchNe = 1'b1;
			opJ:   ctrl.jump = 1'b1;
			opJal:
			begin
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			default: ctrl = '0; // byte/half ops and the rest retire as no-ops
		endcase

		if (ctrl.zeroExtImm)
			imm = {16'h0000, instr.i.imm};
		else
			imm = {{16{instr.i.imm[15]}}, instr.i.imm};
	end

	assign knownInstr = (instr.r.opcode == opRType) ?
		(instr.r.funct inside {fnSll, fnSrl, fnSra, fnJr, fnAdd, fnSub,
			fnAnd, fnOr, fnXor, fnNor, fnSlt}) :
		(instr.r.opcode inside {opJ, opJal, opBeq, opBne, opAddi, opSlti,
			opAndi, opOri, opXori, opLui, opLw, opSw});

	// any word outside the kept subset must leave state and flow untouched
	always_comb
	begin
		if (!knownInstr)
			assert final (!(ctrl.regWrite || ctrl.memWrite || ctrl.branchEq ||
				ctrl.branchNe || ctrl.jump || ctrl.jumpReg))
				else $error("unknown instruction %h enables a write or branch", instr);
	end

endmodule

//--- src/fetchUnit.sv
module fetchUnit
	import isaPkg::*, corePkg::*;
(
	input logic Clock,
	input logic rst,
	input logic run,
	input progWriteT progWrite,
	input ctrlT ctrl,
	input logic equal,
	input wordT imm,
	input wordT rsData,
	output instrT instr,
	output wordT pc,
	output wordT pcPlusOne
);

	wordT imem [imemDepth];
	wordT nextPc;
	wordT branchTarget;
	wordT jumpTarget;
	logic branchTaken;

	// program load port, contents survive reset
	always_ff @(posedge Clock)
	begin
		if (progWrite.strobe)
			imem[progWrite.addr] <= progWrite.data;
	end

	assign instr = imem[pc[imemAddrBits-1:0]]; // combinational fetch

	assign pcPlusOne = pc + 32'd1;
	assign branchTarget = pcPlusOne + imm; // word offset
	assign jumpTarget = {pcPlusOne[31:26], instr.j.target};
	assign branchTaken = (ctrl.branchEq && equal) || (ctrl.branchNe && !equal);

	always_comb
	begin
		if (ctrl.jumpReg)
			nextPc = rsData;
		else if (ctrl.jump)
			nextPc = jumpTarget;
		else if (branchTaken)
			nextPc = branchTarget;
		else
			nextPc = pcPlusOne;
	end

	always_ff @(posedge Clock)
	begin
		if (rst)
			pc <= '0;
		else if (run)
			pc <= nextPc; // one instruction per cycle
	end

	// redirects from decode, register file and branch compare must stay in imem
	pcInRange: assert property (@(posedge Clock) disable iff (rst)
		run |=> pc < imemDepth)
		else $error("pc left instruction memory: %0d", pc);

endmodule

//--- src/corePkg.sv
package corePkg;

	typedef logic [31:0] wordT;

	localparam int imemDepth = 256;
	localparam int dmemDepth = 256;
	localparam int imemAddrBits = 8;
	localparam int dmemAddrBits = 8;

	localparam logic [4:0] raReg = 5'd31; // link register for jal

	// ALU operation codes
	typedef enum logic [3:0]
	{
		aluAnd = 4'b0000,
		aluOr  = 4'b0001,
		aluAdd = 4'b0010,
		aluXor = 4'b0011,
		aluSll = 4'b0100,
		aluSub = 4'b0110,
		aluSlt = 4'b0111,
		aluSrl = 4'b1000,
		aluSra = 4'b1001,
		aluLui = 4'b1010,
		aluNor = 4'b1100
	} aluOpT;

	typedef struct packed
	{
		logic regWrite;
		logic memWrite;
		logic memToReg;   // write back load data
		logic aluSrcImm;  // second operand from the immediate
		logic zeroExtImm;
		logic link;       // jal writes pc plus one to ra
		logic branchEq;
		logic branchNe;
		logic jump;
		logic jumpReg;
		aluOpT aluOp;
	} ctrlT;

	typedef struct packed
	{
		logic strobe;
		logic [imemAddrBits-1:0] addr;
		wordT data;
	} progWriteT;

	typedef struct packed
	{
		logic valid;
		wordT pc;
		logic regWrite;
		logic [4:0] rd;
		wordT regData;
		logic memWrite;
		logic [dmemAddrBits-1:0] memAddr;
		wordT memData;
	} retireT;

endpackage

//--- src/isaPkg.sv
package isaPkg;

	typedef logic [4:0] regIdxT;

	// primary opcode field, bits 31:26
	typedef enum logic [5:0]
	{
		opRType = 6'd0,
		opJ     = 6'd2,
		opJal   = 6'd3,
		opBeq   = 6'd4,
		opBne   = 6'd5,
		opAddi  = 6'd8,
		opSlti  = 6'd10,
		opAndi  = 6'd12,
		opOri   = 6'd13,
		opXori  = 6'd14,
		opLui   = 6'd15,
		opLw    = 6'd35,
		opSw    = 6'd43
	} opcodeT;

	// funct field of R-type words, bits 5:0
	typedef enum logic [5:0]
	{
		fnSll = 6'd0,
		fnSrl = 6'd2,
		fnSra = 6'd3,
		fnJr  = 6'd8,
		fnAdd = 6'd32,
		fnSub = 6'd34,
		fnAnd = 6'd36,
		fnOr  = 6'd37,
		fnXor = 6'd38,
		fnNor = 6'd39,
		fnSlt = 6'd42
	} functT;

	typedef struct packed
	{
		opcodeT opcode;
		regIdxT rs;
		regIdxT rt;
		regIdxT rd;
		logic [4:0] shamt;
		functT funct;
	} rFormatT;

	typedef struct packed
	{
		opcodeT opcode;
		regIdxT rs;
		regIdxT rt;
		logic [15:0] imm;
	} iFormatT;

	typedef struct packed
	{
		opcodeT opcode;
		logic [25:0] target; // word index of the jump destination
	} jFormatT;

	// one instruction word seen through each format
	typedef union packed
	{
		rFormatT r;
		iFormatT i;
		jFormatT j;
	} instrT;

endpackage
